//--- include/scratchpad_pkg.sv
// Scratchpad package
// Word widths and the payload types shared by the port bridges, the arbiter
// and the memory bank
`default_nettype none

package scratchpad_pkg;

  // Word address width, 256 words in all
  localparam int unsigned AddrWidth = 8;
  // Width of one data word
  localparam int unsigned DataWidth = 32;
  // Width of the port tag carried with a command and its response
  localparam int unsigned PortIdxWidth = 1;

  // Command as issued by a requester, 41 bits
  typedef struct packed {
    logic                 we;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
  } req_t;

  // Response word returned to the requester
  typedef struct packed {
    logic [DataWidth-1:0] data;
  } rsp_t;

  // Command with the index of the port that issued it
  typedef struct packed {
    logic [PortIdxWidth-1:0] port;
    req_t                    req;
  } tagged_req_t;

  // Response with the index of the port it belongs to
  typedef struct packed {
    logic [PortIdxWidth-1:0] port;
    rsp_t                    rsp;
  } tagged_rsp_t;

endpackage

`default_nettype wire

//--- sources.f
include/scratchpad_pkg.sv
src/isochronous_spill_register.sv
src/rr_arbiter.sv
src/scratchpad_bank.sv
src/port_bridge.sv
src/iso_scratchpad_top.sv
test/tb_clk_gen.sv
test/tb_scratchpad_checker.sv
test/tb_iso_scratchpad.sv

//--- src/iso_scratchpad_top.sv
// Two-port isochronous scratchpad
// Core-domain requesters reach a shared memory bank in the half-rate memory
// domain through one bridge per port and a round-robin arbiter
`timescale 1ns/1ps
`default_nettype none

module iso_scratchpad_top #(
  parameter  int unsigned Depth    = 256,
  localparam int unsigned NumPorts = 2
) (
  input  logic                                 src_clk_i,
  input  logic                                 dst_clk_i,
  input  logic                                 rst_n_i,
  input  logic [NumPorts-1:0]                  req_valid_i,
  output logic [NumPorts-1:0]                  req_ready_o,
  input  logic [NumPorts-1:0]                  req_we_i,
  input  logic [scratchpad_pkg::AddrWidth-1:0] req_addr_i [NumPorts],
  input  logic [scratchpad_pkg::DataWidth-1:0] req_wdata_i [NumPorts],
  output logic [NumPorts-1:0]                  rsp_valid_o,
  input  logic [NumPorts-1:0]                  rsp_ready_i,
  output logic [scratchpad_pkg::DataWidth-1:0] rsp_data_o [NumPorts]
);
  import scratchpad_pkg::*;

  // Memory-domain command offers from the bridges
  logic [NumPorts-1:0] mem_req_valid;
  logic [NumPorts-1:0] mem_req_ready;
  req_t                mem_req [NumPorts];

  // Arbitrated command and the bank's broadcast response
  logic                cmd_valid;
  tagged_req_t         cmd;
  logic                rsp_strobe;
  tagged_rsp_t         bank_rsp;

  for (genvar p = 0; p < NumPorts; p++) begin : gen_port
    port_bridge #(
      .PortIndex (p)
    ) i_port_bridge (
      .src_clk_i         (src_clk_i),
      .dst_clk_i         (dst_clk_i),
      .rst_n_i           (rst_n_i),
      .req_valid_i       (req_valid_i[p]),
      .req_ready_o       (req_ready_o[p]),
      .req_i             (req_t'{we: req_we_i[p], addr: req_addr_i[p], wdata: req_wdata_i[p]}),
      .rsp_valid_o       (rsp_valid_o[p]),
      .rsp_ready_i       (rsp_ready_i[p]),
      .rsp_o             (rsp_data_o[p]),
      .mem_req_valid_o   (mem_req_valid[p]),
      .mem_req_ready_i   (mem_req_ready[p]),
      .mem_req_o         (mem_req[p]),
      .bank_rsp_strobe_i (rsp_strobe),
      .bank_rsp_i        (bank_rsp)
    );
  end

  rr_arbiter #(
    .NumPorts (NumPorts)
  ) i_rr_arbiter (
    .dst_clk_i   (dst_clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (mem_req_valid),
    .req_i       (mem_req),
    .req_ready_o (mem_req_ready),
    .cmd_valid_o (cmd_valid),
    .cmd_o       (cmd)
  );

  scratchpad_bank #(
    .Depth (Depth)
  ) i_scratchpad_bank (
    .dst_clk_i    (dst_clk_i),
    .cmd_valid_i  (cmd_valid),
    .cmd_i        (cmd),
    .rsp_strobe_o (rsp_strobe),
    .rsp_o        (bank_rsp)
  );

endmodule

`default_nettype wire

//--- src/isochronous_spill_register.sv
// Isochronous spill register
// Two-entry buffer that cuts every combinational path between two clock
// domains derived from one source clock. Static timing covers the crossing,
// so the pointers need no synchronizer stages
`timescale 1ns/1ps
`default_nettype none

module isochronous_spill_register #(
  // Payload carried through the buffer
  parameter type T      = logic,
  // Set to pass the handshake straight through without storage
  parameter bit  Bypass = 1'b0
) (
  input  logic src_clk_i,
  input  logic rst_n_i,
  input  logic src_valid_i,
  output logic src_ready_o,
  input  T     src_data_i,
  input  logic dst_clk_i,
  output logic dst_valid_o,
  input  logic dst_ready_i,
  output T     dst_data_o
);

  if (Bypass) begin : gen_bypass
    // Transparent mode keeps the paths combinational
    assign dst_valid_o = src_valid_i;
    assign src_ready_o = dst_ready_i;
    assign dst_data_o  = src_data_i;
  end else begin : gen_buffer
    // Both pointers carry one extra bit above the entry index
    // Equal pointers mean empty, a difference only in the top bit means full
    logic [1:0] wr_ptr_q;
    logic [1:0] rd_ptr_q;
    T           mem_q [2];
    logic       push;
    logic       pop;

    assign push = src_valid_i && src_ready_o;
    assign pop  = dst_valid_o && dst_ready_i;

    // Write side lives entirely in the source domain
    always_ff @(posedge src_clk_i) begin
      if (!rst_n_i) begin
        wr_ptr_q <= '0;
      end else if (push) begin
        wr_ptr_q <= wr_ptr_q + 2'd1;
      end
    end

    // Storage is written from the source side only
    always_ff @(posedge src_clk_i) begin
      if (push) begin
        mem_q[wr_ptr_q[0]] <= src_data_i;
      end
    end

    // Read side lives entirely in the destination domain
    always_ff @(posedge dst_clk_i) begin
      if (!rst_n_i) begin
        rd_ptr_q <= '0;
      end else if (pop) begin
        rd_ptr_q <= rd_ptr_q + 2'd1;
      end
    end

    // The source may push unless both entries are occupied
    assign src_ready_o = (wr_ptr_q ^ rd_ptr_q) != 2'b10;
    // Any pointer difference means at least one entry waits
    assign dst_valid_o = (wr_ptr_q ^ rd_ptr_q) != 2'b00;
    assign dst_data_o  = mem_q[rd_ptr_q[0]];
  end

  // A pending offer in the source domain is held until it is taken
  assert property (@(posedge src_clk_i) disable iff (!rst_n_i)
    src_valid_i && !src_ready_o |=> $stable(src_valid_i))
    else $error("source valid dropped under back-pressure");

  // The destination side keeps its offer until the consumer takes it
  assert property (@(posedge dst_clk_i) disable iff (!rst_n_i)
    dst_valid_o && !dst_ready_i |=> $stable(dst_valid_o))
    else $error("destination valid dropped under back-pressure");

endmodule

`default_nettype wire

//--- src/port_bridge.sv
// Port bridge
// Carries one port's commands into the memory domain and its responses back
// to the core domain through two spill registers. A credit counter limits the
// port to two commands in flight, so a response always finds room
`timescale 1ns/1ps
`default_nettype none

module port_bridge #(
  parameter int unsigned PortIndex = 0
) (
  input  logic                        src_clk_i,
  input  logic                        dst_clk_i,
  input  logic                        rst_n_i,
  input  logic                        req_valid_i,
  output logic                        req_ready_o,
  input  scratchpad_pkg::req_t        req_i,
  output logic                        rsp_valid_o,
  input  logic                        rsp_ready_i,
  output scratchpad_pkg::rsp_t        rsp_o,
  output logic                        mem_req_valid_o,
  input  logic                        mem_req_ready_i,
  output scratchpad_pkg::req_t        mem_req_o,
  input  logic                        bank_rsp_strobe_i,
  input  scratchpad_pkg::tagged_rsp_t bank_rsp_i
);
  import scratchpad_pkg::*;

  // Commands allowed in flight, which equals the response buffer depth
  localparam logic [1:0] MaxCredits = 2'd2;

  logic [1:0] credit_q;
  logic       has_credit;
  logic       req_spill_ready;
  logic       req_fire;
  logic       rsp_fire;
  logic       rsp_push;
  logic       rsp_spill_ready;

  assign has_credit  = credit_q != 2'd0;
  assign req_ready_o = req_spill_ready && has_credit;
  assign req_fire    = req_valid_i && req_ready_o;
  assign rsp_fire    = rsp_valid_o && rsp_ready_i;

  // Credits go out with each accepted command and return with each delivered
  // response. Both can happen on the same edge
  always_ff @(posedge src_clk_i) begin
    if (!rst_n_i) begin
      credit_q <= MaxCredits;
    end else if (req_fire && !rsp_fire) begin
      credit_q <= credit_q - 2'd1;
    end else if (rsp_fire && !req_fire) begin
      credit_q <= credit_q + 2'd1;
    end
  end

  // Core to memory crossing for the commands
  isochronous_spill_register #(
    .T      (req_t),
    .Bypass (1'b0)
  ) i_req_spill (
    .src_clk_i   (src_clk_i),
    .rst_n_i     (rst_n_i),
    .src_valid_i (req_valid_i && has_credit),
    .src_ready_o (req_spill_ready),
    .src_data_i  (req_i),
    .dst_clk_i   (dst_clk_i),
    .dst_valid_o (mem_req_valid_o),
    .dst_ready_i (mem_req_ready_i),
    .dst_data_o  (mem_req_o)
  );

  // The bank broadcasts every response and only the matching tag is taken
  assign rsp_push = bank_rsp_strobe_i && (bank_rsp_i.port == PortIdxWidth'(PortIndex));

  // Memory to core crossing for the responses
  isochronous_spill_register #(
    .T      (rsp_t),
    .Bypass (1'b0)
  ) i_rsp_spill (
    .src_clk_i   (dst_clk_i),
    .rst_n_i     (rst_n_i),
    .src_valid_i (rsp_push),
    .src_ready_o (rsp_spill_ready),
    .src_data_i  (bank_rsp_i.rsp),
    .dst_clk_i   (src_clk_i),
    .dst_valid_o (rsp_valid_o),
    .dst_ready_i (rsp_ready_i),
    .dst_data_o  (rsp_o)
  );

  // The credit limit guarantees room for every response the bank sends here
  assert property (@(posedge dst_clk_i) disable iff (!rst_n_i)
    rsp_push |-> rsp_spill_ready)
    else $error("response arrived at a full response buffer");

  // Responses never return more credits than were handed out
  assert property (@(posedge src_clk_i) disable iff (!rst_n_i)
    credit_q <= MaxCredits)
    else $error("credit counter overflow");

endmodule

`default_nettype wire

//--- src/rr_arbiter.sv
// Round-robin arbiter
// Picks one port's request per memory cycle for the single-ported bank and
// tags it with the port index. The grant is combinational and the priority
// pointer moves past each granted port
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter #(
  parameter int unsigned NumPorts = 2
) (
  input  logic                        dst_clk_i,
  input  logic                        rst_n_i,
  input  logic [NumPorts-1:0]         req_valid_i,
  input  scratchpad_pkg::req_t        req_i [NumPorts],
  output logic [NumPorts-1:0]         req_ready_o,
  output logic                        cmd_valid_o,
  output scratchpad_pkg::tagged_req_t cmd_o
);
  import scratchpad_pkg::*;

  // Index width, kept at one bit for a single port
  localparam int unsigned IdxWidth = (NumPorts > 1) ? $clog2(NumPorts) : 1;

  logic [IdxWidth-1:0] prio_q;
  logic [IdxWidth-1:0] grant_idx;
  logic [NumPorts-1:0] grant;
  logic                found;

  // Scan the ports starting at the priority pointer
  // The first valid request wins
  always_comb begin
    int unsigned cand;
    grant     = '0;
    grant_idx = '0;
    found     = 1'b0;
    cand      = 0;
    for (int unsigned off = 0; off < NumPorts; off++) begin
      cand = (32'(prio_q) + off) % NumPorts;
      if (!found && req_valid_i[cand]) begin
        found           = 1'b1;
        grant[cand]     = 1'b1;
        grant_idx       = IdxWidth'(cand);
      end
    end
  end

  // The bank accepts a command every cycle, so a grant is a transfer
  always_ff @(posedge dst_clk_i) begin
    if (!rst_n_i) begin
      prio_q <= '0;
    end else if (found) begin
      // The port after the winner has priority next time
      if (grant_idx == IdxWidth'(NumPorts - 1)) begin
        prio_q <= '0;
      end else begin
        prio_q <= grant_idx + 1'b1;
      end
    end
  end

  // Only the granted port sees ready
  assign req_ready_o = grant;
  assign cmd_valid_o = found;

  // Forward the winning request with its port tag
  assign cmd_o.port = PortIdxWidth'(grant_idx);
  assign cmd_o.req  = req_i[grant_idx];

  // At most one port is granted per memory cycle
  assert property (@(posedge dst_clk_i) disable iff (!rst_n_i)
    $onehot0(grant))
    else $error("grant is not one-hot");

  // A grant only goes to a port that raised valid
  assert property (@(posedge dst_clk_i) disable iff (!rst_n_i)
    (grant & ~req_valid_i) == '0)
    else $error("grant given to an idle port");

endmodule

`default_nettype wire

//--- src/scratchpad_bank.sv
// Scratchpad memory bank
// Single-ported word memory in the memory domain. Every command produces a
// response one cycle later that carries the port tag of the command
`timescale 1ns/1ps
`default_nettype none

module scratchpad_bank #(
  parameter int unsigned Depth = 256
) (
  input  logic                        dst_clk_i,
  input  logic                        cmd_valid_i,
  input  scratchpad_pkg::tagged_req_t cmd_i,
  output logic                        rsp_strobe_o,
  output scratchpad_pkg::tagged_rsp_t rsp_o
);
  import scratchpad_pkg::*;

  logic [DataWidth-1:0] mem_q [Depth];
  logic                 strobe_q;
  tagged_rsp_t          rsp_q;

  // Array storage with a single access per cycle
  always_ff @(posedge dst_clk_i) begin
    if (cmd_valid_i && cmd_i.req.we) begin
      mem_q[cmd_i.req.addr] <= cmd_i.req.wdata;
    end
  end

  // Strobe follows the command by exactly one memory cycle
  always_ff @(posedge dst_clk_i) begin
    strobe_q <= cmd_valid_i;
  end

  // Response payload
  // A write echoes the stored data and a read returns the old word
  always_ff @(posedge dst_clk_i) begin
    if (cmd_valid_i) begin
      rsp_q.port <= cmd_i.port;
      if (cmd_i.req.we) begin
        rsp_q.rsp.data <= cmd_i.req.wdata;
      end else begin
        rsp_q.rsp.data <= mem_q[cmd_i.req.addr];
      end
    end
  end

  assign rsp_strobe_o = strobe_q;
  assign rsp_o        = rsp_q;

endmodule

`default_nettype wire

//--- test/tb_clk_gen.sv
// Testbench clock and reset source
// Makes the 4 ns core clock, the half-rate memory clock from the same edges
// and a reset held for four core cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic src_clk_o,
  output logic dst_clk_o,
  output logic rst_n_o
);

  // One process drives both clocks, so their rising edges share a time step
  initial begin
    src_clk_o = 1'b0;
    dst_clk_o = 1'b0;
    forever begin
      #2;
      src_clk_o = 1'b1;
      // The memory clock toggles on every core rising edge
      dst_clk_o = ~dst_clk_o;
      #2;
      src_clk_o = 1'b0;
    end
  end

  // Reset is released on a falling edge, away from both clocks
  initial begin
    rst_n_o = 1'b0;
    repeat (4) @(posedge src_clk_o);
    @(negedge src_clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- test/tb_iso_scratchpad.sv
// Testbench for the two-port isochronous scratchpad
// Drives both ports on the falling core clock edge through directed and
// random phases. Port 0 works below address 128 and port 1 above it
`timescale 1ns/1ps
`default_nettype none

module tb_iso_scratchpad;
  import scratchpad_pkg::*;

  // Response ready modes per port
  localparam int ready_high   = 0;
  localparam int ready_low    = 1;
  localparam int ready_random = 2;

  logic                 src_clk;
  logic                 dst_clk;
  logic                 rst_n;
  logic [1:0]           req_valid;
  logic [1:0]           req_ready;
  logic [1:0]           req_we;
  logic [AddrWidth-1:0] req_addr [2];
  logic [DataWidth-1:0] req_wdata [2];
  logic [1:0]           rsp_valid;
  logic [1:0]           rsp_ready = 2'b11;
  logic [DataWidth-1:0] rsp_data [2];
  int                   rsp_mode [2];
  int                   issued [2];
  int                   timeout_count;
  int                   check_count;
  int                   base;
  integer               seed = 32'hd663_8f0f;

  tb_clk_gen clk_gen_i (
    .src_clk_o (src_clk),
    .dst_clk_o (dst_clk),
    .rst_n_o   (rst_n)
  );

  iso_scratchpad_top #(
    .Depth (256)
  ) iso_scratchpad_top_i (
    .src_clk_i   (src_clk),
    .dst_clk_i   (dst_clk),
    .rst_n_i     (rst_n),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .req_we_i    (req_we),
    .req_addr_i  (req_addr),
    .req_wdata_i (req_wdata),
    .rsp_valid_o (rsp_valid),
    .rsp_ready_i (rsp_ready),
    .rsp_data_o  (rsp_data)
  );

  tb_scratchpad_checker scratchpad_checker_i (
    .clk_i       (src_clk),
    .rst_n_i     (rst_n),
    .req_valid_i (req_valid),
    .req_ready_i (req_ready),
    .req_we_i    (req_we),
    .req_addr_i  (req_addr),
    .req_wdata_i (req_wdata),
    .rsp_valid_i (rsp_valid),
    .rsp_ready_i (rsp_ready),
    .rsp_data_i  (rsp_data)
  );

  // Response back-pressure changes only on falling edges
  always @(negedge src_clk) begin
    for (int p = 0; p < 2; p++) begin
      if (rsp_mode[p] == ready_random) begin
        rsp_ready[p] = ($random(seed) & 1) != 0;
      end else begin
        rsp_ready[p] = (rsp_mode[p] == ready_high);
      end
    end
  end

  // Presents one command and holds it until the port accepts it
  task automatic issue_cmd(input int p, input logic we, input logic [AddrWidth-1:0] addr,
                           input logic [DataWidth-1:0] wdata);
    int cycles;
    bit taken;
    cycles = 0;
    taken  = 1'b0;
    @(negedge src_clk);
    req_valid[p] = 1'b1;
    req_we[p]    = we;
    req_addr[p]  = addr;
    req_wdata[p] = wdata;
    while (!taken && cycles < 200) begin
      @(posedge src_clk);
      taken = req_ready[p];
      cycles++;
    end
    if (taken) begin
      issued[p]++;
    end else begin
      $display("TIMEOUT: %s port %0d never accepted its request",
               scratchpad_checker_i.test_name, p);
      timeout_count++;
    end
  endtask

  task automatic release_port(input int p);
    @(negedge src_clk);
    req_valid[p] = 1'b0;
  endtask

  // Waits until every accepted request of a port has its response
  task automatic wait_drain(input int p);
    int cycles;
    cycles = 0;
    while (scratchpad_checker_i.rsp_count[p] != scratchpad_checker_i.acc_count[p]
           && cycles < 500) begin
      @(negedge src_clk);
      cycles++;
    end
    if (scratchpad_checker_i.rsp_count[p] != scratchpad_checker_i.acc_count[p]) begin
      $display("TIMEOUT: %s port %0d still owes responses", scratchpad_checker_i.test_name, p);
      timeout_count++;
    end
  endtask

  // Random reads and writes inside a 16-word window of the port's half
  task automatic random_port(input int p, input int n, input int max_gap);
    logic                 we;
    logic [DataWidth-1:0] wdata;
    int                   offset;
    int                   gap;
    for (int i = 0; i < n; i++) begin
      we     = 1'($random(seed));
      wdata  = $random(seed);
      offset = $unsigned($random(seed)) % 16;
      issue_cmd(p, we, AddrWidth'(p * 128 + offset), wdata);
      if (max_gap > 0) begin
        gap = $unsigned($random(seed)) % (max_gap + 1);
        release_port(p);
        repeat (gap) @(negedge src_clk);
      end
    end
    release_port(p);
  endtask

  initial begin
    int cycles;
    req_valid = '0;
    req_we    = '0;
    for (int p = 0; p < 2; p++) begin
      req_addr[p]  = '0;
      req_wdata[p] = '0;
    end
    cycles = 0;
    while (rst_n !== 1'b1 && cycles < 20) begin
      @(negedge src_clk);
      cycles++;
    end
    if (rst_n !== 1'b1) begin
      $display("TIMEOUT: reset was never released");
      timeout_count++;
    end

    // Idle ports stay ready and never produce a response
    scratchpad_checker_i.test_name = "reset_state";
    repeat (10) begin
      @(negedge src_clk);
      scratchpad_checker_i.check_ports(2'b11, 2'b00);
    end

    scratchpad_checker_i.test_name = "write_read";
    issue_cmd(0, 1'b1, 8'd5, 32'hcafe_0005);
    issue_cmd(0, 1'b0, 8'd5, '0);
    release_port(0);
    issue_cmd(1, 1'b1, 8'd133, 32'hbeef_0085);
    issue_cmd(1, 1'b0, 8'd133, '0);
    release_port(1);
    wait_drain(0);
    wait_drain(1);

    scratchpad_checker_i.test_name = "random_mixed";
    fork
      random_port(0, 200, 0);
      random_port(1, 200, 0);
    join
    wait_drain(0);
    wait_drain(1);

    // Two credits let two writes through, then the third command must wait
    scratchpad_checker_i.test_name = "backpressure";
    rsp_mode[0] = ready_low;
    base = scratchpad_checker_i.acc_count[0];
    issue_cmd(0, 1'b1, 8'd20, 32'h1111_0014);
    issue_cmd(0, 1'b1, 8'd21, 32'h2222_0015);
    fork
      issue_cmd(0, 1'b0, 8'd20, '0);
      begin
        repeat (20) @(negedge src_clk);
        if (scratchpad_checker_i.acc_count[0] - base > 2) begin
          $display("ERROR: backpressure port 0 accepted more than two requests");
          check_count++;
        end
        scratchpad_checker_i.check_ports(2'b10, 2'b01);
        rsp_mode[0] = ready_high;
      end
    join
    release_port(0);
    wait_drain(0);

    scratchpad_checker_i.test_name = "random_toggle";
    rsp_mode[0] = ready_random;
    rsp_mode[1] = ready_random;
    fork
      random_port(0, 150, 3);
      random_port(1, 150, 3);
    join
    rsp_mode[0] = ready_high;
    rsp_mode[1] = ready_high;
    wait_drain(0);
    wait_drain(1);
    // Every request the stimulus saw accepted returns exactly one response
    for (int p = 0; p < 2; p++) begin
      if (scratchpad_checker_i.rsp_count[p] != issued[p]) begin
        $display("MISMATCH: random_toggle port %0d responses expected %0d actual %0d", p,
                 issued[p], scratchpad_checker_i.rsp_count[p]);
        check_count++;
      end
    end

    $display("Error counts: mismatch %0d, protocol %0d, check %0d, timeout %0d",
             scratchpad_checker_i.mismatch_count, scratchpad_checker_i.protocol_count,
             check_count, timeout_count);
    if (scratchpad_checker_i.mismatch_count + scratchpad_checker_i.protocol_count
        + check_count + timeout_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- test/tb_scratchpad_checker.sv
// Scratchpad scoreboard
// Mirrors the bank in a memory model, predicts every response when its request
// is accepted and compares it with the response the DUT delivers
`timescale 1ns/1ps
`default_nettype none

module tb_scratchpad_checker (
  input logic                                 clk_i,
  input logic                                 rst_n_i,
  input logic [1:0]                           req_valid_i,
  input logic [1:0]                           req_ready_i,
  input logic [1:0]                           req_we_i,
  input logic [scratchpad_pkg::AddrWidth-1:0] req_addr_i [2],
  input logic [scratchpad_pkg::DataWidth-1:0] req_wdata_i [2],
  input logic [1:0]                           rsp_valid_i,
  input logic [1:0]                           rsp_ready_i,
  input logic [scratchpad_pkg::DataWidth-1:0] rsp_data_i [2]
);
  import scratchpad_pkg::*;

  // Name of the running test, shown in every error line
  string test_name = "idle";
  int    mismatch_count;
  int    protocol_count;
  // Accepted requests and delivered responses per port
  int    acc_count [2];
  int    rsp_count [2];

  // Words stay unknown until written, and a read of one expects unknown too
  logic [DataWidth-1:0] model_mem [256];

  // A write answers with its own data, a read with the word stored before it
  function automatic logic [DataWidth-1:0] expected_rsp(
    input logic                 we,
    input logic [DataWidth-1:0] wdata,
    input logic [DataWidth-1:0] stored
  );
    return we ? wdata : stored;
  endfunction

  // Compares the handshake outputs against a state the test expects
  task automatic check_ports(input logic [1:0] exp_ready, input logic [1:0] exp_valid);
    if (req_ready_i !== exp_ready) begin
      $display("MISMATCH: %s req_ready expected %b actual %b", test_name, exp_ready,
               req_ready_i);
      mismatch_count++;
    end
    if (rsp_valid_i !== exp_valid) begin
      $display("MISMATCH: %s rsp_valid expected %b actual %b", test_name, exp_valid,
               rsp_valid_i);
      mismatch_count++;
    end
  endtask

  for (genvar p = 0; p < 2; p++) begin : gen_port
    // Responses still owed to this port, oldest first
    logic [DataWidth-1:0] exp_q [$];
    logic [DataWidth-1:0] exp_word;

    always @(posedge clk_i) begin
      if (rst_n_i) begin
        // Prediction at acceptance keeps the model in request order
        if (req_valid_i[p] && req_ready_i[p]) begin
          exp_q.push_back(expected_rsp(req_we_i[p], req_wdata_i[p],
                                       model_mem[req_addr_i[p]]));
          if (req_we_i[p]) begin
            model_mem[req_addr_i[p]] = req_wdata_i[p];
          end
          acc_count[p]++;
        end
        if (rsp_valid_i[p] && rsp_ready_i[p]) begin
          rsp_count[p]++;
          if (exp_q.size() == 0) begin
            $display("ERROR: %s port %0d delivered a response with no request pending",
                     test_name, p);
            protocol_count++;
          end else begin
            exp_word = exp_q.pop_front();
            if (rsp_data_i[p] !== exp_word) begin
              $display("MISMATCH: %s port %0d expected 0x%08h actual 0x%08h", test_name, p,
                       exp_word, rsp_data_i[p]);
              mismatch_count++;
            end
          end
        end
      end
    end
  end

endmodule

`default_nettype wire
